//--- icache_top.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_way.sv
logic/icache_front.sv
logic/icache_refill.sv
logic/icache_hit_merge.sv
logic/icache_top.sv
verification/icache_assert.sv
verification/icache_checker.sv
verification/icache_tb.sv

//--- logic/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// --------------------------------------------------
// cache geometry
// --------------------------------------------------

`define ICACHE_WAYS         2   // 1, 2 or 4
`define ICACHE_SETS_LOG2    4   // 16 sets
`define ICACHE_WORDS_LOG2   2   // 4 words per line

// --------------------------------------------------
// derived sizes
// --------------------------------------------------

`define ICACHE_SETS         (1 << `ICACHE_SETS_LOG2)
`define ICACHE_WORDS        (1 << `ICACHE_WORDS_LOG2)

// tag = what is left above index, word and byte bits
`define ICACHE_TAG_W        (32 - `ICACHE_SETS_LOG2 - `ICACHE_WORDS_LOG2 - 2)

`define ICACHE_LINE_W       (32 * `ICACHE_WORDS)    // 128 bits

`endif

//--- logic/icache_front.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_front
    import icache_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,

    // core side
    input  logic                    ifu_valid,   // held until ifu_ready
    input  logic [31:0]             addr,
    output logic                    ifu_ready,   // one-cycle pulse
    output logic [31:0]             data,        // valid with ifu_ready

    // toward ways and refill engine
    output fetch_addr_t             lookup,
    input  logic                    any_hit,
    input  logic [31:0]             hit_word,
    output logic                    refill_start,
    output logic [`ICACHE_WAYS-1:0] victim,      // one-hot
    input  logic                    refill_done
);

    // --------------------------------------------------
    // state encoding
    // --------------------------------------------------

    localparam logic [1:0] s_idle    = 2'd0;
    localparam logic [1:0] s_compare = 2'd1;   // ways look at lookup
    localparam logic [1:0] s_refill  = 2'd2;   // line on its way in
    localparam logic [1:0] s_respond = 2'd3;   // data held while ready pulses

    logic [1:0]              state;
    logic                    load_resp;        // capture merged word
    logic [`ICACHE_WAYS-1:0] rr [`ICACHE_SETS]; // per-set victim pointer

    // rotate a one-hot pointer by one way
    function automatic logic [`ICACHE_WAYS-1:0] rotl(input logic [`ICACHE_WAYS-1:0] v);
        rotl = (v << 1) | (v >> (`ICACHE_WAYS - 1));
    endfunction

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= s_idle;
            ifu_ready <= 1'b0;
        end else begin
            ifu_ready <= 1'b0;                  // pulse by default
            case (state)
                s_idle: begin
                    if (ifu_valid) state <= s_compare;
                end
                s_compare: begin
                    state <= any_hit ? s_respond : s_compare == s_compare ? s_refill : s_refill;
                end
                s_refill: begin
                    // line written on the last beat so the compare repeats here
                    if (refill_done) state <= any_hit ? s_respond : s_compare;
                end
                s_respond: begin
                    ifu_ready <= 1'b1;
                    state     <= s_idle;        // next request on following edge
                end
                default: state <= s_idle;
            endcase
        end
    end

    assign load_resp = any_hit & ((state == s_compare) |
                                  ((state == s_refill) & refill_done));

    // --------------------------------------------------
    // request and response registers
    // --------------------------------------------------

    // request held for the ways and the refill engine
    always_ff @(posedge clock) begin
        if (reset) begin
            lookup <= '0;
        end else if (state == s_idle && ifu_valid) begin
            lookup <= fetch_addr_t'(addr);
        end
    end

    always_ff @(posedge clock) begin
        if (load_resp) data <= hit_word;
    end

    // --------------------------------------------------
    // miss handling and round robin
    // --------------------------------------------------

    assign refill_start = (state == s_compare) & ~any_hit;
    assign victim       = rr[lookup.index];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                rr[s] <= `ICACHE_WAYS'(1);  // way 0 goes first
            end
        end else if (refill_start) begin
            rr[lookup.index] <= rotl(rr[lookup.index]);
        end
    end

endmodule

//--- logic/icache_hit_merge.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_hit_merge
    import icache_pkg::*;
(
    input  way_result_t results [`ICACHE_WAYS],  // one per way
    output logic        any_hit,
    output logic [31:0] hit_word,
    output logic        multi_hit                // more than one way matched
);

    // --------------------------------------------------
    // reduction over ways
    // --------------------------------------------------

    always_comb begin
        logic seen;

        seen      = 1'b0;
        any_hit   = 1'b0;
        hit_word  = '0;
        multi_hit = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (results[w].hit) begin
                multi_hit = multi_hit | seen;   // second hit seen
                seen      = 1'b1;
            end
            any_hit  = any_hit | results[w].hit;
            // one-hot and-or, no priority
            hit_word = hit_word | (results[w].word & {32{results[w].hit}});
        end
    end

endmodule

//--- logic/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    // --------------------------------------------------
    // fetch address split into cache fields
    // --------------------------------------------------

    // msb first, so a plain 32-bit cast lines up
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]      tag;      // upper bits
        logic [`ICACHE_SETS_LOG2-1:0]  index;    // set select
        logic [`ICACHE_WORDS_LOG2-1:0] word;     // word in line
        logic [1:0]                    byte_off; // always 0 for fetch
    } fetch_addr_t;

    // --------------------------------------------------
    // one returned bus word on its way into a way
    // --------------------------------------------------

    typedef struct packed {
        logic                          wr;       // beat present this cycle
        logic [`ICACHE_SETS_LOG2-1:0]  index;    // target set
        logic [`ICACHE_WORDS_LOG2-1:0] word;     // position in line
        logic [`ICACHE_WAYS-1:0]       way_sel;  // one-hot victim
        logic                          last;     // final beat of line
        logic [31:0]                   data;
    } refill_beat_t;

    // --------------------------------------------------
    // per-way lookup answer
    // --------------------------------------------------

    typedef struct packed {
        logic        hit;   // tag match and valid
        logic [31:0] word;  // addressed word of that way's line
    } way_result_t;

endpackage

//--- logic/icache_refill.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_refill
    import icache_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,

    // from front end
    input  logic                    refill_start,  // one-cycle strobe
    input  logic [`ICACHE_WAYS-1:0] victim,
    input  fetch_addr_t             lookup,        // held through refill

    // memory bus
    output logic                    chvalid,
    output logic [31:0]             chaddr,
    output logic [7:0]              chlen,
    input  logic                    chready,       // one beat per high cycle
    input  logic [31:0]             chdata,

    // toward ways
    output refill_beat_t            beat,
    output logic                    refill_done
);

    // --------------------------------------------------
    // beat bookkeeping
    // --------------------------------------------------

    localparam logic [`ICACHE_WORDS_LOG2-1:0] last_word = `ICACHE_WORDS_LOG2'(`ICACHE_WORDS - 1);

    logic [`ICACHE_WORDS_LOG2-1:0] count;      // words already taken
    logic [`ICACHE_WAYS-1:0]       way_sel;    // victim kept for whole line
    logic                          take;       // beat accepted this cycle
    logic                          last_beat;

    assign take      = chvalid & chready;
    assign last_beat = (count == last_word);
    assign chlen     = 8'(`ICACHE_WORDS - 1);  // beats minus one

    // --------------------------------------------------
    // bus request
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            chvalid     <= 1'b0;
            count       <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= 1'b0;
            if (refill_start) begin
                chvalid <= 1'b1;
                count   <= '0;
            end else if (take) begin
                count <= count + 1'b1;
                if (last_beat) begin
                    chvalid     <= 1'b0;        // drop after final word
                    refill_done <= 1'b1;        // ways already written
                end
            end
        end
    end

    // address and victim, loaded at start
    always_ff @(posedge clock) begin
        if (refill_start) begin
            chaddr  <= {lookup.tag, lookup.index, {(`ICACHE_WORDS_LOG2 + 2){1'b0}}};
            way_sel <= victim;
        end else if (take) begin
            chaddr <= chaddr + 32'd4;          // next word
        end
    end

    // --------------------------------------------------
    // beat to the ways
    // --------------------------------------------------

    always_comb begin
        beat.wr      = take;
        beat.index   = lookup.index;
        beat.word    = count;
        beat.way_sel = way_sel;
        beat.last    = last_beat;
        beat.data    = chdata;
    end

endmodule

//--- logic/icache_top.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    // fetch port
    input  logic [31:0] addr,
    input  logic        ifu_valid,
    output logic [31:0] data,
    output logic        ifu_ready,

    // memory read bus
    output logic        chvalid,
    output logic [31:0] chaddr,
    output logic [7:0]  chlen,
    input  logic        chready,
    input  logic [31:0] chdata,

    output logic        err_multi_hit   // status for core error log
);

    // --------------------------------------------------
    // internal wiring
    // --------------------------------------------------

    fetch_addr_t             lookup;
    refill_beat_t            beat;
    way_result_t             results [`ICACHE_WAYS];
    logic                    any_hit;
    logic [31:0]             hit_word;
    logic                    refill_start;
    logic [`ICACHE_WAYS-1:0] victim;
    logic                    refill_done;

    icache_front i_icache_front (
        .clock, .reset,
        .ifu_valid, .addr, .ifu_ready, .data,
        .lookup, .any_hit, .hit_word,
        .refill_start, .victim, .refill_done
    );

    icache_refill i_icache_refill (
        .clock, .reset,
        .refill_start, .victim, .lookup,
        .chvalid, .chaddr, .chlen, .chready, .chdata,
        .beat, .refill_done
    );

    // --------------------------------------------------
    // ways
    // --------------------------------------------------

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_way #(.way_id(w)) i_icache_way (
            .clock, .reset,
            .lookup,
            .beat,          // all ways see it, way_sel picks one
            .result (results[w])
        );
    end

    icache_hit_merge i_icache_hit_merge (
        .results,
        .any_hit, .hit_word,
        .multi_hit (err_multi_hit)
    );

endmodule

//--- logic/icache_way.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_way
    import icache_pkg::*;
#(
    parameter int way_id = 0    // position in the way array
) (
    input  logic         clock,
    input  logic         reset,
    input  fetch_addr_t  lookup,   // latched fetch request
    input  refill_beat_t beat,     // shared refill beat
    output way_result_t  result
);

    // --------------------------------------------------
    // storage
    // --------------------------------------------------

    logic [`ICACHE_TAG_W-1:0]  tags  [`ICACHE_SETS];
    logic [`ICACHE_LINE_W-1:0] lines [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]   valid;

    logic we;           // beat is aimed at this way
    logic tag_match;

    assign we = beat.wr & beat.way_sel[way_id];

    // --------------------------------------------------
    // valid bits and tags
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (we) begin
            // line is half old, half new until the last beat lands
            valid[beat.index] <= beat.last;
        end
    end

    // tag comes from the held request, it does not change during refill
    always_ff @(posedge clock) begin
        if (we && beat.last) begin
            tags[beat.index] <= lookup.tag;
        end
    end

    // one 32-bit slot per beat
    always_ff @(posedge clock) begin
        if (we) begin
            lines[beat.index][beat.word*32 +: 32] <= beat.data;
        end
    end

    // --------------------------------------------------
    // lookup
    // --------------------------------------------------

    assign tag_match = (tags[lookup.index] == lookup.tag);

    always_comb begin
        result.hit  = valid[lookup.index] & tag_match;
        result.word = lines[lookup.index][lookup.word*32 +: 32]; // word mux
    end

endmodule

//--- verification/icache_assert.sv
`timescale 1ns/10ps

module icache_assert (
    input logic        clock,
    input logic        reset,
    input logic        chvalid,
    input logic        chready,
    input logic [31:0] chaddr,
    input logic        ifu_ready,
    input logic        err_multi_hit
);

    int failures = 0;   // summed into the closing count

    // --------------------------------------------------
    // memory bus
    // --------------------------------------------------

    a_chvalid_hold: assert property (@(posedge clock) disable iff (reset)
        chvalid && !chready |=> chvalid)
        else begin
            $error("chvalid dropped with no beat taken");
            failures++;
        end

    // last beat steps too, the next start reloads it
    a_chaddr_step: assert property (@(posedge clock) disable iff (reset)
        chvalid && chready |=> chaddr == $past(chaddr) + 32'd4)
        else begin
            $error("chaddr did not step by one word after a beat");
            failures++;
        end

    // --------------------------------------------------
    // fetch side
    // --------------------------------------------------

    a_ready_pulse: assert property (@(posedge clock) disable iff (reset)
        ifu_ready |=> !ifu_ready)
        else begin
            $error("ifu_ready stayed high for more than one cycle");
            failures++;
        end

    a_no_multi_hit: assert property (@(posedge clock) disable iff (reset)
        !err_multi_hit)
        else begin
            $error("err_multi_hit raised, a line sits in two ways");
            failures++;
        end

endmodule

bind icache_top icache_assert i_icache_assert (.*);

//--- verification/icache_checker.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_checker (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] addr,
    input  logic        ifu_valid,
    input  logic [31:0] data,
    input  logic        ifu_ready,
    input  logic        chvalid,
    input  logic [31:0] chaddr,
    input  logic [7:0]  chlen,
    input  logic        chready,
    input  logic        err_multi_hit,
    output int          data_errors,
    output int          bus_errors,
    output int          flow_errors,
    output int          fetches
);

    // memory content of a word address
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        expected_word = (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]};
    endfunction

    // shadow tags, round robin per set
    logic [`ICACHE_TAG_W-1:0] sh_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic                     sh_valid [`ICACHE_SETS][`ICACHE_WAYS];
    int                       sh_next  [`ICACHE_SETS];

    logic [31:0] held;          // accepted address
    logic [31:0] line_base;
    logic        busy;
    logic        want_hit;      // shadow prediction
    logic        chvalid_q;
    int          cycle, accept_cycle, last_beat_cycle, requests, beats, idx;

    always @(posedge clock) begin
        cycle = cycle + 1;
        if (reset) begin
            busy        = 1'b0;
            chvalid_q   = 1'b0;
            data_errors = 0;
            bus_errors  = 0;
            flow_errors = 0;
            fetches     = 0;
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                sh_next[s] = 0;
                for (int w = 0; w < `ICACHE_WAYS; w++) sh_valid[s][w] = 1'b0;
            end
        end else begin
            if (err_multi_hit) begin
                $display("ERROR err_multi_hit: expected %h, got %h", 1'b0, err_multi_hit);
                flow_errors++;
            end
            if (busy) begin
                if (chvalid && !chvalid_q) begin    // new bus request
                    requests++;
                    if (chaddr !== line_base) begin
                        $display("ERROR chaddr: expected %h, got %h", line_base, chaddr);
                        bus_errors++;
                    end
                    if (chlen !== 8'(`ICACHE_WORDS - 1)) begin
                        $display("ERROR chlen: expected %h, got %h",
                                 8'(`ICACHE_WORDS - 1), chlen);
                        bus_errors++;
                    end
                end
                if (chvalid && chready) begin       // beat taken this edge
                    if (chaddr !== line_base + 32'(4 * beats)) begin
                        $display("ERROR chaddr: expected %h, got %h",
                                 line_base + 32'(4 * beats), chaddr);
                        bus_errors++;
                    end
                    beats++;
                    last_beat_cycle = cycle;
                end
                if (ifu_ready) begin
                    fetches++;
                    if (data !== expected_word(held)) begin
                        $display("ERROR data: expected %h, got %h at address %h",
                                 expected_word(held), data, held);
                        data_errors++;
                    end
                    // ready rises two edges after the deciding edge, seen on the third
                    if (want_hit && (requests != 0 || cycle - accept_cycle != 3)) begin
                        $display("hit at address %h made %0d bus requests, answered after %0d",
                                 held, requests, cycle - accept_cycle);
                        flow_errors++;
                    end
                    if (!want_hit && (requests != 1 || beats != `ICACHE_WORDS ||
                                      cycle - last_beat_cycle != 3)) begin
                        $display("miss at address %h made %0d requests and %0d beats",
                                 held, requests, beats);
                        flow_errors++;
                    end
                    busy = 1'b0;
                end
            end else if (chvalid || ifu_ready) begin
                $display("bus request or ifu_ready seen with no fetch pending");
                flow_errors++;
            end
            if (!busy && ifu_valid) begin       // DUT idle, request taken here
                busy         = 1'b1;
                held         = addr;
                line_base    = {addr[31:`ICACHE_WORDS_LOG2+2], {(`ICACHE_WORDS_LOG2+2){1'b0}}};
                accept_cycle = cycle;
                requests     = 0;
                beats        = 0;
                idx          = int'(addr[`ICACHE_WORDS_LOG2+2 +: `ICACHE_SETS_LOG2]);
                want_hit     = 1'b0;
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (sh_valid[idx][w] && sh_tag[idx][w] == addr[31 -: `ICACHE_TAG_W])
                        want_hit = 1'b1;
                end
                if (!want_hit) begin            // refill lands in the round-robin way
                    sh_tag[idx][sh_next[idx]]   = addr[31 -: `ICACHE_TAG_W];
                    sh_valid[idx][sh_next[idx]] = 1'b1;
                    sh_next[idx]                = (sh_next[idx] + 1) % `ICACHE_WAYS;
                end
            end
            chvalid_q = chvalid;
        end
    end

endmodule

//--- verification/icache_tb.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_tb;

    localparam int wait_limit = 200;    // cycles allowed per fetch

    logic        clock;
    logic        reset;
    logic [31:0] addr;
    logic        ifu_valid;
    logic [31:0] data;
    logic        ifu_ready;
    logic        chvalid;
    logic [31:0] chaddr;
    logic [7:0]  chlen;
    logic        chready;
    logic [31:0] chdata;
    logic        err_multi_hit;

    integer      seed       = 32'hd7f5_c8cd;    // stimulus
    integer      stall_seed = 32'hd7f5_c8cd;    // memory stalls
    int          timeouts   = 0;
    int          data_errors, bus_errors, flow_errors, fetches;
    logic [31:0] last_addr;

    icache_top i_icache_top (.*);

    icache_checker i_icache_checker (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // --------------------------------------------------
    // memory model
    // --------------------------------------------------

    function automatic logic [31:0] memory_word(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        memory_word = (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]};
    endfunction

    always @(negedge clock) begin
        chready = ({$random(stall_seed)} % 4) != 0;    // stall about one cycle in four
        chdata  = chvalid ? memory_word(chaddr) : 32'h0;
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    // repeat, same line, same set or anywhere
    function automatic logic [31:0] next_address(input logic [31:0] prev);
        logic [31:0] r;
        logic [31:0] a;
        r = $random(seed);
        case (r[1:0])
            2'd0: a = prev;
            2'd1: a = {prev[31:`ICACHE_WORDS_LOG2+2], r[4 +: `ICACHE_WORDS_LOG2], 2'b00};
            2'd2: a = {`ICACHE_TAG_W'(r[9:8]),    // four tags fight over one set
                       prev[`ICACHE_WORDS_LOG2+2 +: `ICACHE_SETS_LOG2],
                       r[4 +: `ICACHE_WORDS_LOG2], 2'b00};
            default: begin
                a = $random(seed);
                a[1:0] = 2'b00;
            end
        endcase
        next_address = a;
    endfunction

    task automatic finish_run();
        $display("fetches %0d, data errors %0d, bus errors %0d, flow errors %0d, %s %0d, %s %0d",
                 fetches, data_errors, bus_errors, flow_errors,
                 "assertion failures", i_icache_top.i_icache_assert.failures,
                 "timeouts", timeouts);
        if (data_errors + bus_errors + flow_errors + timeouts +
            i_icache_top.i_icache_assert.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // hold the request from a falling edge until ifu_ready
    task automatic fetch(input logic [31:0] a);
        int n;
        if (timeouts == 0) begin        // nothing more once the DUT hung
            addr      = a;
            ifu_valid = 1'b1;
            n         = 0;
            @(negedge clock);
            while (!ifu_ready && n < wait_limit) begin
                @(negedge clock);
                n++;
            end
            if (ifu_ready) begin
                ifu_valid = 1'b0;
                last_addr = a;
            end else begin
                $display("no ifu_ready within %0d cycles for address %h", wait_limit, a);
                timeouts++;
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        ifu_valid = 1'b0;
        addr      = 32'h0;
        chready   = 1'b0;
        chdata    = 32'h0;
        last_addr = 32'h0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (4) @(negedge clock);    // quiet bus before first fetch

        // whole line, then three lines in set 4
        fetch(32'h0000_1040);
        for (int w = 0; w < `ICACHE_WORDS; w++) fetch(32'h0000_1040 + 32'(4 * w));
        fetch(32'h0000_2040);
        fetch(32'h0000_3040);           // evicts the first line
        fetch(32'h0000_2044);
        fetch(32'h0000_1048);

        for (int i = 0; i < 400 && timeouts == 0; i++) begin
            fetch(next_address(last_addr));
            repeat ({$random(seed)} % 3) @(negedge clock);    // idle gap
        end
        finish_run();
    end

endmodule
